//--- filelist.f
+incdir+include
verilog/ex_pkg.sv
verilog/ex_alu_stage.sv
verilog/ex_resolve_stage.sv
verilog/ex_unit.sv
tb/ex_unit_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module ex_unit_tb -f filelist.f
output=$(./obj_dir/Vex_unit_tb)
echo "$output"

if echo "$output" | grep -q "Simulation PASSED"; then
    exit 0
fi
exit 1

//--- include/ex_ref_model.svh
`ifndef EX_REF_MODEL_SVH
`define EX_REF_MODEL_SVH

// signed order by flipping the sign bit
function automatic logic [XLEN-1:0] ref_alu(ex_fn_e fn, logic [XLEN-1:0] a,
                                            logic [XLEN-1:0] b);
    logic [SHAMT_W-1:0] sh;
    logic [XLEN-1:0]    sign_flip;
    logic [XLEN-1:0]    r;
    sh        = b[SHAMT_W-1:0];
    sign_flip = {1'b1, {(XLEN-1){1'b0}}};
    case (fn)
        FN_ADD:  r = a + b;
        FN_SUB:  r = a + ~b + 1'b1;
        FN_SLL:  r = a << sh;
        FN_SLT:  r = XLEN'((a ^ sign_flip) < (b ^ sign_flip));
        FN_SLTU: r = XLEN'(a < b);
        FN_XOR:  r = a ^ b;
        FN_SRL:  r = a >> sh;
        FN_SRA:  r = (a >> sh) | (a[XLEN-1] ? ~({XLEN{1'b1}} >> sh) : '0);
        FN_OR:   r = a | b;
        FN_AND:  r = a & b;
        default: r = '0;
    endcase
    return r;
endfunction

function automatic logic ref_taken(ex_req_t req);
    logic [XLEN-1:0] sign_flip;
    sign_flip = {1'b1, {(XLEN-1){1'b0}}};
    if (req.op == OP_JAL || req.op == OP_JALR) begin
        return 1'b1;
    end
    if (req.op != OP_BRANCH) begin
        return 1'b0;
    end
    case (req.fn)
        FN_BEQ:  return req.rs1 == req.rs2;
        FN_BNE:  return req.rs1 != req.rs2;
        FN_BLT:  return (req.rs1 ^ sign_flip) < (req.rs2 ^ sign_flip);
        FN_BGE:  return !((req.rs1 ^ sign_flip) < (req.rs2 ^ sign_flip));
        FN_BLTU: return req.rs1 < req.rs2;
        FN_BGEU: return !(req.rs1 < req.rs2);
        default: return 1'b0;
    endcase
endfunction

function automatic ex_res_t ref_res(ex_req_t req);
    ex_res_t r;
    r.rd    = req.rd;
    r.wen   = !(req.op inside {OP_BRANCH, OP_STORE});
    r.wdata = '0;
    case (req.op)
        OP_LUI:          r.wdata = req.imm;
        OP_AUIPC:        r.wdata = req.pc + req.imm;
        OP_JAL, OP_JALR: r.wdata = req.pc + 32'd4;
        OP_IMM:          r.wdata = ref_alu(req.fn, req.rs1, req.imm);
        OP_REG:          r.wdata = ref_alu(req.fn, req.rs1, req.rs2);
        default:         r.wdata = '0;
    endcase
    return r;
endfunction

function automatic ex_mem_t ref_mem(ex_req_t req);
    ex_mem_t m;
    m.en    = req.op inside {OP_LOAD, OP_STORE};
    m.we    = req.op == OP_STORE;
    m.addr  = req.rs1 + req.imm;
    m.wdata = m.we ? req.rs2 : '0;
    m.size  = req.fn;
    return m;
endfunction

function automatic ex_redirect_t ref_redirect(ex_req_t req);
    ex_redirect_t d;
    d.valid  = ref_taken(req);
    d.target = (req.op == OP_JALR) ? req.rs1 + req.imm : req.pc + req.imm;
    return d;
endfunction

`endif

//--- tb/ex_unit_tb.sv
`timescale 1ns/1ps

module ex_unit_tb
    import ex_pkg::*;
();

    `include "ex_ref_model.svh"

    localparam int RESET_CYC   = 5;
    localparam int IDLE_CYC    = 4;
    localparam int N_RAND      = 300;
    localparam int N_BRANCH    = 18;
    localparam int STIM_CYC    = RESET_CYC + 2 * IDLE_CYC + N_RAND + 3 * N_BRANCH;
    localparam int TIMEOUT_CYC = 2 * STIM_CYC + 50;
    localparam int SHOW_W      = 96;

    typedef struct packed {
        int           due;
        ex_res_t      res;
        ex_mem_t      mem;
        ex_redirect_t redirect;
    } exp_t;

    logic         clk_i;
    logic         arst_n_i;
    logic         req_valid_i;
    ex_req_t      req_i;
    logic         res_valid_o;
    ex_res_t      res_o;
    ex_mem_t      mem_o;
    ex_redirect_t redirect_o;

    logic [31:0]  rng;
    int           cyc;
    int           squash_cnt;
    int           value_errs;
    int           flow_errs;
    logic         squashed;
    exp_t         new_exp;
    exp_t         exp_q[$];
    logic         exp_valid;
    exp_t         exp_cur;

    ex_unit i_dut (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .res_valid_o (res_valid_o),
        .res_o       (res_o),
        .mem_o       (mem_o),
        .redirect_o  (redirect_o)
    );

    always #2 clk_i = ~clk_i;

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic ex_req_t random_req();
        ex_req_t     r;
        logic [31:0] sel;
        sel   = next_rand();
        r.pc  = next_rand() & 32'hFFFF_FFFC;
        r.op  = ex_op_e'(4'(sel % 9));
        r.imm = next_rand();
        r.rs1 = next_rand();
        // equal operands now and then so BEQ and BGE see ties
        r.rs2 = (sel[9:8] == 2'b00) ? r.rs1 : next_rand();
        r.rd  = 5'(sel >> 10);
        case (r.op)
            OP_BRANCH: r.fn = ex_fn_e'(5'(FN_BEQ + (sel >> 16) % 6));
            OP_LOAD:   r.fn = ex_fn_e'(5'(FN_BYTE + (sel >> 16) % 5));
            OP_STORE:  r.fn = ex_fn_e'(5'(FN_BYTE + (sel >> 16) % 3));
            default:   r.fn = ex_fn_e'(5'((sel >> 16) % 10));
        endcase
        if (r.op == OP_IMM && r.fn == FN_SUB) begin
            r.fn = FN_ADD;
        end
        return r;
    endfunction

    function automatic ex_req_t non_redirect_req();
        ex_req_t r;
        r = random_req();
        while (r.op inside {OP_JAL, OP_JALR, OP_BRANCH}) begin
            r = random_req();
        end
        return r;
    endfunction

    task automatic present_req(input logic valid, input ex_req_t r);
        req_valid_i = valid;
        req_i       = r;
        @(posedge clk_i);
        #1;
    endtask

    // negative, positive and equal pairs, so signed and unsigned compares disagree
    task automatic branch_sweep();
        ex_req_t         r;
        logic [XLEN-1:0] pair_a [3];
        logic [XLEN-1:0] pair_b [3];
        pair_a = '{32'hFFFF_FFF0, 32'hFFFF_FFF0, 32'h0000_0010};
        pair_b = '{32'hFFFF_FFF0, 32'h0000_0010, 32'hFFFF_FFF0};
        for (int f = 0; f < 6; f++) begin
            for (int p = 0; p < 3; p++) begin
                // two plain requests ahead keep each branch clear of an older redirect
                repeat (2) present_req(1'b1, non_redirect_req());
                r     = random_req();
                r.op  = OP_BRANCH;
                r.fn  = ex_fn_e'(5'(FN_BEQ + f));
                r.rs1 = pair_a[p];
                r.rs2 = pair_b[p];
                present_req(1'b1, r);
            end
        end
    endtask

    task automatic report_mismatch(input string name, input logic [SHOW_W-1:0] exp_v,
                                   input logic [SHOW_W-1:0] got_v);
        value_errs = value_errs + 1;
        $display("FAIL t=%0t %s expected %h got %h", $time, name, exp_v, got_v);
    endtask

    // expectation moves at the same edge as the dut output registers
    always @(posedge clk_i) begin
        cyc = cyc + 1;
        if (!arst_n_i) begin
            exp_q.delete();
            squash_cnt = 0;
            exp_valid <= 1'b0;
        end else begin
            if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
                exp_valid <= 1'b1;
                exp_cur   <= exp_q.pop_front();
            end else begin
                exp_valid <= 1'b0;
            end
            squashed = squash_cnt != 0;
            if (squashed) begin
                squash_cnt = squash_cnt - 1;
            end
            if (req_valid_i && !squashed) begin
                new_exp.due      = cyc + 1;
                new_exp.res      = ref_res(req_i);
                new_exp.mem      = ref_mem(req_i);
                new_exp.redirect = ref_redirect(req_i);
                exp_q.push_back(new_exp);
                // redirect kills the next two accepted slots
                if (new_exp.redirect.valid) begin
                    squash_cnt = 2;
                end
            end
        end
    end

    a_unexpected: assert property (@(posedge clk_i)
        !exp_valid |-> !res_valid_o && !mem_o.en && !redirect_o.valid)
        else begin
            flow_errs = flow_errs + 1;
            $display("output valid at %0t with no expectation due", $time);
        end

    a_missing: assert property (@(posedge clk_i) exp_valid |-> res_valid_o)
        else begin
            flow_errs = flow_errs + 1;
            $display("expected result missing at %0t", $time);
        end

    a_res: assert property (@(posedge clk_i)
        exp_valid && res_valid_o |-> res_o == exp_cur.res)
        else report_mismatch("res_o", SHOW_W'($sampled(exp_cur.res)), SHOW_W'($sampled(res_o)));

    a_mem: assert property (@(posedge clk_i) exp_valid && res_valid_o |->
        mem_o.en == exp_cur.mem.en && (!mem_o.en || mem_o == exp_cur.mem))
        else report_mismatch("mem_o", SHOW_W'($sampled(exp_cur.mem)), SHOW_W'($sampled(mem_o)));

    a_redirect: assert property (@(posedge clk_i) exp_valid && res_valid_o |->
        redirect_o.valid == exp_cur.redirect.valid
        && (!redirect_o.valid || redirect_o.target == exp_cur.redirect.target))
        else report_mismatch("redirect_o", SHOW_W'($sampled(exp_cur.redirect)),
                             SHOW_W'($sampled(redirect_o)));

    initial begin
        while (cyc < TIMEOUT_CYC) begin
            @(posedge clk_i);
        end
        $display("timeout after %0d cycles, results never drained", cyc);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        clk_i       = 1'b0;
        arst_n_i    = 1'b1;
        req_valid_i = 1'b0;
        req_i       = '0;
        rng         = 32'd36349;
        cyc         = 0;
        squash_cnt  = 0;
        value_errs  = 0;
        flow_errs   = 0;
        #1;
        arst_n_i = 1'b0;
        repeat (RESET_CYC) @(posedge clk_i);
        #1;
        arst_n_i = 1'b1;
        repeat (IDLE_CYC) present_req(1'b0, '0);
        for (int i = 0; i < N_RAND; i++) begin
            present_req(next_rand() % 8 != 0, random_req());
        end
        branch_sweep();
        repeat (IDLE_CYC) present_req(1'b0, '0);
        while (exp_q.size() != 0 || exp_valid) begin
            @(posedge clk_i);
            #1;
        end
        @(posedge clk_i);
        #1;
        $display("errors: %0d value, %0d flow", value_errs, flow_errs);
        if (value_errs == 0 && flow_errs == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- verilog/ex_alu_stage.sv
`timescale 1ns/1ps

module ex_alu_stage
    import ex_pkg::*;
(
    input  logic    clk_i,
    input  logic    arst_n_i,
    input  logic    req_valid_i,
    input  ex_req_t req_i,
    input  logic    flush_i,
    output logic    mid_valid_o,
    output ex_mid_t mid_o
);

    logic               req_valid_q;
    ex_req_t            req_q;
    logic [XLEN-1:0]    op_b;
    logic [SHAMT_W-1:0] shamt;
    logic [XLEN-1:0]    alu_res;
    logic [XLEN-1:0]    pc_imm;
    logic [XLEN-1:0]    rs1_imm;
    logic               taken;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            req_valid_q <= 1'b0;
        end else begin
            req_valid_q <= req_valid_i & ~flush_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_valid_i) begin
            req_q <= req_i;
        end
    end

    assign op_b  = (req_q.op == OP_IMM) ? req_q.imm : req_q.rs2;
    assign shamt = op_b[SHAMT_W-1:0];

    always_comb begin
        case (req_q.fn)
            FN_ADD:  alu_res = req_q.rs1 + op_b;
            FN_SUB:  alu_res = req_q.rs1 - op_b;
            FN_SLL:  alu_res = req_q.rs1 << shamt;
            FN_SLT:  alu_res = {{(XLEN-1){1'b0}}, $signed(req_q.rs1) < $signed(op_b)};
            FN_SLTU: alu_res = {{(XLEN-1){1'b0}}, req_q.rs1 < op_b};
            FN_XOR:  alu_res = req_q.rs1 ^ op_b;
            FN_SRL:  alu_res = req_q.rs1 >> shamt;
            FN_SRA:  alu_res = $signed(req_q.rs1) >>> shamt;
            FN_OR:   alu_res = req_q.rs1 | op_b;
            FN_AND:  alu_res = req_q.rs1 & op_b;
            default: alu_res = '0;
        endcase
    end

    assign pc_imm  = req_q.pc + req_q.imm;
    assign rs1_imm = req_q.rs1 + req_q.imm;

    // jumps always redirect, branches on their compare
    always_comb begin
        taken = 1'b0;
        case (req_q.op)
            OP_JAL, OP_JALR: taken = 1'b1;
            OP_BRANCH: begin
                case (req_q.fn)
                    FN_BEQ:  taken = req_q.rs1 == req_q.rs2;
                    FN_BNE:  taken = req_q.rs1 != req_q.rs2;
                    FN_BLT:  taken = $signed(req_q.rs1) < $signed(req_q.rs2);
                    FN_BGE:  taken = $signed(req_q.rs1) >= $signed(req_q.rs2);
                    FN_BLTU: taken = req_q.rs1 < req_q.rs2;
                    FN_BGEU: taken = req_q.rs1 >= req_q.rs2;
                    default: taken = 1'b0;
                endcase
            end
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        mid_o.op    = req_q.op;
        mid_o.fn    = req_q.fn;
        mid_o.rd    = req_q.rd;
        mid_o.rs2   = req_q.rs2;
        mid_o.taken = taken;
        case (req_q.op)
            OP_LUI:          mid_o.value = req_q.imm;
            OP_AUIPC:        mid_o.value = pc_imm;
            OP_JAL, OP_JALR: mid_o.value = req_q.pc + XLEN'(INSN_BYTES);
            default:         mid_o.value = alu_res;
        endcase
        case (req_q.op)
            OP_JALR, OP_LOAD, OP_STORE: mid_o.addr = rs1_imm;
            default:                    mid_o.addr = pc_imm;
        endcase
    end

    assign mid_valid_o = req_valid_q & ~flush_i;

    // the held request and the one presented with the flush both die here
    a_flush_squash: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        flush_i |-> !mid_valid_o ##1 !mid_valid_o
    );

endmodule

//--- verilog/ex_pkg.sv
package ex_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int SHAMT_W    = 5;
    localparam int INSN_BYTES = 4;

    // instruction class, as decoded upstream
    typedef enum logic [3:0] {
        OP_LUI,
        OP_AUIPC,
        OP_JAL,
        OP_JALR,
        OP_BRANCH,
        OP_LOAD,
        OP_STORE,
        OP_IMM,
        OP_REG
    } ex_op_e;

    // alu functions, then branch conditions, then access sizes
    typedef enum logic [4:0] {
        FN_ADD,
        FN_SUB,
        FN_SLL,
        FN_SLT,
        FN_SLTU,
        FN_XOR,
        FN_SRL,
        FN_SRA,
        FN_OR,
        FN_AND,
        FN_BEQ,
        FN_BNE,
        FN_BLT,
        FN_BGE,
        FN_BLTU,
        FN_BGEU,
        FN_BYTE,
        FN_HALF,
        FN_WORD,
        FN_BYTE_U,
        FN_HALF_U
    } ex_fn_e;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        ex_op_e                op;
        ex_fn_e                fn;
        logic [XLEN-1:0]       imm;
        logic [XLEN-1:0]       rs1;
        logic [XLEN-1:0]       rs2;
        logic [REG_ADDR_W-1:0] rd;
    } ex_req_t;

    // value is the alu result, immediate or link; addr is address or target
    typedef struct packed {
        ex_op_e                op;
        ex_fn_e                fn;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       value;
        logic [XLEN-1:0]       addr;
        logic [XLEN-1:0]       rs2;
        logic                  taken;
    } ex_mid_t;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] rd;
        logic                  wen;
        logic [XLEN-1:0]       wdata;
    } ex_res_t;

    typedef struct packed {
        logic            en;
        logic            we;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
        ex_fn_e          size;
    } ex_mem_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] target;
    } ex_redirect_t;

endpackage

//--- verilog/ex_resolve_stage.sv
`timescale 1ns/1ps

module ex_resolve_stage
    import ex_pkg::*;
(
    input  logic         clk_i,
    input  logic         arst_n_i,
    input  logic         mid_valid_i,
    input  ex_mid_t      mid_i,
    output logic         res_valid_o,
    output ex_res_t      res_o,
    output ex_mem_t      mem_o,
    output ex_redirect_t redirect_o
);

    logic            wen;
    logic            is_load;
    logic            is_store;
    logic            res_valid_q;
    logic            mem_en_q;
    logic            redirect_valid_q;
    ex_res_t         res_q;
    logic            mem_we_q;
    logic [XLEN-1:0] addr_q;
    logic [XLEN-1:0] mem_wdata_q;
    ex_fn_e          mem_size_q;

    always_comb begin
        case (mid_i.op)
            OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_LOAD, OP_IMM, OP_REG: wen = 1'b1;
            default: wen = 1'b0;
        endcase
    end

    assign is_load  = mid_i.op == OP_LOAD;
    assign is_store = mid_i.op == OP_STORE;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            res_valid_q      <= 1'b0;
            mem_en_q         <= 1'b0;
            redirect_valid_q <= 1'b0;
        end else begin
            res_valid_q      <= mid_valid_i;
            mem_en_q         <= mid_valid_i & (is_load | is_store);
            redirect_valid_q <= mid_valid_i & mid_i.taken;
        end
    end

    // load data arrives later from memory, so wdata stays zero for loads
    always_ff @(posedge clk_i) begin
        if (mid_valid_i) begin
            res_q.rd    <= mid_i.rd;
            res_q.wen   <= wen;
            res_q.wdata <= (wen && !is_load) ? mid_i.value : '0;
            mem_we_q    <= is_store;
            addr_q      <= mid_i.addr;
            mem_wdata_q <= is_store ? mid_i.rs2 : '0;
            mem_size_q  <= mid_i.fn;
        end
    end

    assign res_valid_o = res_valid_q;
    assign res_o       = res_q;

    always_comb begin
        mem_o.en          = mem_en_q;
        mem_o.we          = mem_we_q;
        mem_o.addr        = addr_q;
        mem_o.wdata       = mem_wdata_q;
        mem_o.size        = mem_size_q;
        redirect_o.valid  = redirect_valid_q;
        redirect_o.target = addr_q;
    end

    // two younger requests are squashed through the flush loop
    a_redirect_gap: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        redirect_o.valid |-> res_valid_o ##1 !res_valid_o [*2]
    );

    a_mem_qualified: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        mem_o.en |-> res_valid_o && !(mem_o.we && res_o.wen)
    );

endmodule

//--- verilog/ex_unit.sv
`timescale 1ns/1ps

module ex_unit
    import ex_pkg::*;
(
    input  logic         clk_i,
    input  logic         arst_n_i,
    input  logic         req_valid_i,
    input  ex_req_t      req_i,
    output logic         res_valid_o,
    output ex_res_t      res_o,
    output ex_mem_t      mem_o,
    output ex_redirect_t redirect_o
);

    logic    mid_valid;
    ex_mid_t mid;
    logic    flush;

    // redirect is already registered, so it feeds back directly
    assign flush = redirect_o.valid;

    ex_alu_stage u_alu_stage (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .flush_i     (flush),
        .mid_valid_o (mid_valid),
        .mid_o       (mid)
    );

    ex_resolve_stage u_resolve_stage (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .mid_valid_i (mid_valid),
        .mid_i       (mid),
        .res_valid_o (res_valid_o),
        .res_o       (res_o),
        .mem_o       (mem_o),
        .redirect_o  (redirect_o)
    );

endmodule
